// File: logic/fetch_consts.svh
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// fixed bus widths of the front end
`define ADDR_W 32
`define INST_W 32
`define PFN_W  20

// boot vector in kseg1
`define RESET_PC      32'hbfc00000

// exception entry points while BEV is set
`define GENERAL_EX_PC 32'hbfc00380
`define REFILL_EX_PC  32'hbfc00200

// strips the segment bits of kseg0/kseg1
`define PHYS_MASK     32'h1fffffff

`endif

// File: logic/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // where the next fetch PC comes from
    typedef enum logic [2:0] {
        PC_SEQ        = 3'd0,
        PC_PRED       = 3'd1,
        PC_REDIRECT   = 3'd2,
        PC_REFETCH    = 3'd3,
        PC_GENERAL_EX = 3'd4,
        PC_REFILL_EX  = 3'd5,
        PC_ERET       = 3'd6
    } pc_src_e;

    // four-phase icache request states
    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        // req high, waiting for ack
        ST_REQ     = 2'd1,
        // req low, waiting for ack to drop
        ST_RELEASE = 2'd2,
        // result presented to the fetch stage
        ST_HOLD    = 2'd3
    } fetch_state_e;

endpackage

`default_nettype wire

// File: logic/exc_pkg.sv
`default_nettype none

package exc_pkg;

    // exceptions detected at PC generation
    typedef enum logic [1:0] {
        EXC_NONE        = 2'd0,
        // misaligned fetch address
        EXC_ADEL        = 2'd1,
        // no matching TLB entry
        EXC_TLB_REFILL  = 2'd2,
        // entry found but page not valid
        EXC_TLB_INVALID = 2'd3
    } fetch_exc_e;

endpackage

`default_nettype wire

// File: logic/next_pc_sel.sv
`default_nettype none
`include "fetch_consts.svh"

module next_pc_sel (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     pc_load,
    input  var  fetch_pkg::pc_src_e pc_src,
    input  wire [`ADDR_W-1:0]       bpu_target,
    input  wire [`ADDR_W-1:0]       br_target,
    input  wire [`ADDR_W-1:0]       refetch_pc,
    input  wire [`ADDR_W-1:0]       epc,
    output logic [`ADDR_W-1:0]      pc
);

    logic [`ADDR_W-1:0] pc_next;
    // set once the PC came from a target that may be misaligned
    logic               misalign_ok;

    always_comb begin
        case (pc_src)
            fetch_pkg::PC_SEQ:        pc_next = pc + 32'd4;
            fetch_pkg::PC_PRED:       pc_next = bpu_target;
            fetch_pkg::PC_REDIRECT:   pc_next = br_target;
            fetch_pkg::PC_REFETCH:    pc_next = refetch_pc;
            fetch_pkg::PC_GENERAL_EX: pc_next = `GENERAL_EX_PC;
            fetch_pkg::PC_REFILL_EX:  pc_next = `REFILL_EX_PC;
            fetch_pkg::PC_ERET:       pc_next = epc;
            default:                  pc_next = pc + 32'd4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RESET_PC;
        end else if (pc_load) begin
            pc <= pc_next;
        end
    end

    // sequential and predicted steps keep the current alignment origin
    always_ff @(posedge clk) begin
        if (reset) begin
            misalign_ok <= 1'b0;
        end else if (pc_load) begin
            if (pc_src == fetch_pkg::PC_ERET || pc_src == fetch_pkg::PC_REDIRECT) begin
                misalign_ok <= 1'b1;
            end else if (pc_src == fetch_pkg::PC_GENERAL_EX
                         || pc_src == fetch_pkg::PC_REFILL_EX
                         || pc_src == fetch_pkg::PC_REFETCH) begin
                misalign_ok <= 1'b0;
            end
        end
    end

    // only an eret or a branch target can bring a misaligned PC in
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (reset)
        misalign_ok || pc[1:0] == 2'b00
    ) else $error("pc %h misaligned without eret or branch target", pc);

endmodule

`default_nettype wire

// File: logic/itlb_translate.sv
`default_nettype none
`include "fetch_consts.svh"

module itlb_translate (
    input  wire [`ADDR_W-1:0]        pc,
    input  wire                      tlb_found,
    input  wire                      tlb_v0,
    input  wire                      tlb_v1,
    input  wire [`PFN_W-1:0]         tlb_pfn0,
    input  wire [`PFN_W-1:0]         tlb_pfn1,
    output logic [`ADDR_W-1:0]       paddr,
    output exc_pkg::fetch_exc_e      exc
);

    logic              unmapped;
    logic              odd_page;
    logic [`PFN_W-1:0] sel_pfn;
    logic              sel_v;
    logic              misaligned;

    // kseg0 and kseg1 bypass the TLB
    assign unmapped = pc[31:30] == 2'b10;

    // bit 12 picks the even or odd half of the entry pair
    assign odd_page = pc[12];
    assign sel_pfn  = odd_page ? tlb_pfn1 : tlb_pfn0;
    assign sel_v    = odd_page ? tlb_v1 : tlb_v0;

    assign misaligned = pc[1:0] != 2'b00;

    always_comb begin
        if (unmapped) begin
            paddr = pc & `PHYS_MASK;
        end else begin
            paddr = {sel_pfn, pc[11:0]};
        end
    end

    // address error outranks any TLB fault
    always_comb begin
        if (misaligned) begin
            exc = exc_pkg::EXC_ADEL;
        end else if (!unmapped && !tlb_found) begin
            exc = exc_pkg::EXC_TLB_REFILL;
        end else if (!unmapped && !sel_v) begin
            exc = exc_pkg::EXC_TLB_INVALID;
        end else begin
            exc = exc_pkg::EXC_NONE;
        end
    end

endmodule

`default_nettype wire

// File: logic/fetch_ctrl.sv
`default_nettype none
`include "fetch_consts.svh"

module fetch_ctrl (
    input  wire                       clk,
    input  wire                       reset,
    input  wire  [`ADDR_W-1:0]        pc,
    input  wire  [`ADDR_W-1:0]        paddr,
    input  var   exc_pkg::fetch_exc_e exc,
    input  wire                       bpu_valid,
    input  wire                       flush,
    input  wire                       flush_refill,
    input  wire                       refetch,
    input  wire                       eret,
    input  wire                       br_redirect,
    output logic                      pc_load,
    output fetch_pkg::pc_src_e        pc_src,
    output logic                      icache_req,
    output logic [`ADDR_W-1:0]        icache_addr,
    input  wire                       icache_ack,
    input  wire  [`INST_W-1:0]        icache_rdata,
    output logic                      fs_valid,
    output logic [`ADDR_W-1:0]        fs_pc,
    output logic [`INST_W-1:0]        fs_inst,
    output exc_pkg::fetch_exc_e       fs_exc,
    input  wire                       fs_allowin
);

    fetch_pkg::fetch_state_e state;
    // the in-flight result belongs to a PC that was redirected away
    logic                    kill;
    logic                    redirect;
    logic                    transfer;

    assign redirect = eret | flush | br_redirect;
    assign transfer = fs_valid & fs_allowin;
    assign pc_load  = redirect | transfer;

    always_comb begin
        if (eret) begin
            pc_src = fetch_pkg::PC_ERET;
        end else if (flush && flush_refill) begin
            pc_src = fetch_pkg::PC_REFILL_EX;
        end else if (flush && refetch) begin
            pc_src = fetch_pkg::PC_REFETCH;
        end else if (flush) begin
            pc_src = fetch_pkg::PC_GENERAL_EX;
        end else if (br_redirect) begin
            pc_src = fetch_pkg::PC_REDIRECT;
        end else if (bpu_valid) begin
            pc_src = fetch_pkg::PC_PRED;
        end else begin
            pc_src = fetch_pkg::PC_SEQ;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= fetch_pkg::ST_IDLE;
            icache_req <= 1'b0;
            fs_valid   <= 1'b0;
            kill       <= 1'b0;
        end else begin
            case (state)
                fetch_pkg::ST_IDLE: begin
                    // wait for the new PC when redirected here
                    if (!redirect && exc != exc_pkg::EXC_NONE) begin
                        state    <= fetch_pkg::ST_HOLD;
                        fs_valid <= 1'b1;
                    end else if (!redirect) begin
                        state      <= fetch_pkg::ST_REQ;
                        icache_req <= 1'b1;
                    end
                end
                fetch_pkg::ST_REQ: begin
                    if (redirect) begin
                        kill <= 1'b1;
                    end
                    if (icache_ack) begin
                        icache_req <= 1'b0;
                        state      <= fetch_pkg::ST_RELEASE;
                    end
                end
                fetch_pkg::ST_RELEASE: begin
                    if (!icache_ack) begin
                        kill <= 1'b0;
                        if (kill || redirect) begin
                            state <= fetch_pkg::ST_IDLE;
                        end else begin
                            state    <= fetch_pkg::ST_HOLD;
                            fs_valid <= 1'b1;
                        end
                    end else if (redirect) begin
                        kill <= 1'b1;
                    end
                end
                default: begin
                    if (redirect || fs_allowin) begin
                        fs_valid <= 1'b0;
                        state    <= fetch_pkg::ST_IDLE;
                    end
                end
            endcase
        end
    end

    // pc stays put until pc_load, so the request context is taken at issue
    always_ff @(posedge clk) begin
        if (state == fetch_pkg::ST_IDLE && !redirect) begin
            icache_addr <= paddr;
            fs_pc       <= pc;
            fs_exc      <= exc;
            fs_inst     <= '0;
        end else if (state == fetch_pkg::ST_REQ && icache_ack) begin
            fs_inst <= icache_rdata;
        end
    end

    a_addr_stable: assert property (
        @(posedge clk) disable iff (reset)
        icache_req |=> !icache_req || $stable(icache_addr)
    ) else $error("icache_addr changed while req high");

    // ack still high from the last handshake keeps req low
    a_req_after_ack: assert property (
        @(posedge clk) disable iff (reset)
        !icache_req && icache_ack |=> !icache_req
    ) else $error("icache_req rose while ack still high");

    a_fs_hold: assert property (
        @(posedge clk) disable iff (reset)
        fs_valid && !fs_allowin && !redirect |=>
            fs_valid && $stable(fs_pc) && $stable(fs_inst) && $stable(fs_exc)
    ) else $error("fetch stage outputs changed under back-pressure");

endmodule

`default_nettype wire

// File: logic/pre_fetch_top.sv
`default_nettype none
`include "fetch_consts.svh"

module pre_fetch_top (
    input  wire                  clk,
    input  wire                  reset,
    // redirects from execute and commit
    input  wire                  flush,
    input  wire                  flush_refill,
    input  wire                  refetch,
    input  wire [`ADDR_W-1:0]    refetch_pc,
    input  wire                  eret,
    input  wire [`ADDR_W-1:0]    epc,
    input  wire                  br_redirect,
    input  wire [`ADDR_W-1:0]    br_target,
    input  wire                  bpu_valid,
    input  wire [`ADDR_W-1:0]    bpu_target,
    // single-entry TLB view
    input  wire                  tlb_found,
    input  wire [`PFN_W-1:0]     tlb_pfn0,
    input  wire                  tlb_v0,
    input  wire [`PFN_W-1:0]     tlb_pfn1,
    input  wire                  tlb_v1,
    output logic                 icache_req,
    output logic [`ADDR_W-1:0]   icache_addr,
    input  wire                  icache_ack,
    input  wire [`INST_W-1:0]    icache_rdata,
    output logic                 fs_valid,
    output logic [`ADDR_W-1:0]   fs_pc,
    output logic [`INST_W-1:0]   fs_inst,
    output exc_pkg::fetch_exc_e  fs_exc,
    input  wire                  fs_allowin
);

    logic [`ADDR_W-1:0]  pc;
    logic [`ADDR_W-1:0]  paddr;
    exc_pkg::fetch_exc_e exc;
    logic                pc_load;
    fetch_pkg::pc_src_e  pc_src;

    next_pc_sel u_next_pc (
        .clk(clk), .reset(reset), .pc_load(pc_load), .pc_src(pc_src),
        .bpu_target(bpu_target), .br_target(br_target), .refetch_pc(refetch_pc),
        .epc(epc), .pc(pc)
    );

    itlb_translate u_itlb (
        .pc(pc), .tlb_found(tlb_found), .tlb_v0(tlb_v0), .tlb_v1(tlb_v1),
        .tlb_pfn0(tlb_pfn0), .tlb_pfn1(tlb_pfn1), .paddr(paddr), .exc(exc)
    );

    fetch_ctrl u_ctrl (
        .clk(clk), .reset(reset), .pc(pc), .paddr(paddr), .exc(exc),
        .bpu_valid(bpu_valid), .flush(flush), .flush_refill(flush_refill),
        .refetch(refetch), .eret(eret), .br_redirect(br_redirect),
        .pc_load(pc_load), .pc_src(pc_src),
        .icache_req(icache_req), .icache_addr(icache_addr),
        .icache_ack(icache_ack), .icache_rdata(icache_rdata),
        .fs_valid(fs_valid), .fs_pc(fs_pc), .fs_inst(fs_inst), .fs_exc(fs_exc),
        .fs_allowin(fs_allowin)
    );

endmodule

`default_nettype wire

// File: test/tb_fetch_checks.svh
`ifndef TB_FETCH_CHECKS_SVH
`define TB_FETCH_CHECKS_SVH

// one cycle, ending where inputs are driven and outputs have settled
task automatic next_cycle;
    @(posedge clk);
    #drive_delay;
endtask

task automatic check_pc(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        $display("Error %s expected %h got %h", name, exp, got);
        report_failure();
    end
endtask

task automatic check_inst(input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        $display("Error fs_inst expected %h got %h", exp, got);
        report_failure();
    end
endtask

task automatic check_exc(input exc_pkg::fetch_exc_e got, input exc_pkg::fetch_exc_e exp);
    if (got !== exp) begin
        $display("Error fs_exc expected %h got %h", exp, got);
        report_failure();
    end
endtask

task automatic wait_fs_valid;
    int cycles;
    cycles = 0;
    while (fs_valid !== 1'b1) begin
        if (cycles == wait_limit) begin
            $display("Timeout: fs_valid did not rise within %0d cycles", wait_limit);
            report_failure();
        end
        next_cycle();
        cycles++;
    end
endtask

task automatic wait_req(input logic level);
    int cycles;
    cycles = 0;
    while (icache_req !== level) begin
        if (cycles == wait_limit) begin
            $display("Timeout: icache_req did not go to %0b within %0d cycles",
                     level, wait_limit);
            report_failure();
        end
        next_cycle();
        cycles++;
    end
endtask

`endif

// File: test/tb_pre_fetch.sv
`default_nettype none
`include "fetch_consts.svh"

module tb_pre_fetch;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int wait_limit  = 50;
    localparam int drive_delay = 2;

    // DUT inputs start inactive, with reset held
    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic        flush = 1'b0;
    logic        flush_refill = 1'b0;
    logic        refetch = 1'b0;
    logic        eret = 1'b0;
    logic        br_redirect = 1'b0;
    logic        bpu_valid = 1'b0;
    logic [31:0] refetch_pc = 32'hbfc01000;
    logic [31:0] epc = 32'hbfc02000;
    logic [31:0] br_target = 32'hbfc00400;
    logic [31:0] bpu_target = 32'hbfc00100;
    logic        tlb_found = 1'b1;
    logic        tlb_v0 = 1'b1;
    logic        tlb_v1 = 1'b1;
    logic [19:0] tlb_pfn0 = 20'h0abcd;
    logic [19:0] tlb_pfn1 = 20'h12345;
    logic        icache_ack = 1'b0;
    logic [31:0] icache_rdata = '0;
    logic        fs_allowin = 1'b1;
    logic        icache_req;
    logic        fs_valid;
    logic [31:0] icache_addr;
    logic [31:0] fs_pc;
    logic [31:0] fs_inst;
    exc_pkg::fetch_exc_e fs_exc;
    // cache bus monitor
    logic        req_prev = 1'b0;
    logic        ack_prev = 1'b0;
    int          req_rises = 0;
    logic [31:0] req_addr = '0;

    pre_fetch_top i_dut (.*);

    task automatic report_failure;
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    `include "tb_fetch_checks.svh"

    initial begin
        forever #20 clk = ~clk;
    end

    // sampled on the falling edge, away from the driving point
    always @(negedge clk) begin
        if (icache_req === 1'b1 && req_prev !== 1'b1) begin
            // ack from the previous falling edge is its level when req rose
            if (ack_prev !== 1'b0) begin
                $display("icache_req rose while icache_ack was still high");
                report_failure();
            end
            req_rises = req_rises + 1;
            req_addr  = icache_addr;
        end
        req_prev = icache_req;
        ack_prev = icache_ack;
    end

    // four-phase responder, ack raised and dropped after 0 to 3 cycles
    task automatic serve_cache;
        int delay;
        forever begin
            next_cycle();
            if (icache_req) begin
                delay = $urandom_range(3);
                repeat (delay) next_cycle();
                icache_rdata = icache_addr ^ 32'ha5a5a5a5;
                icache_ack   = 1'b1;
                wait_req(1'b0);
                delay = $urandom_range(3);
                repeat (delay) next_cycle();
                icache_ack = 1'b0;
            end
        end
    endtask

    initial begin
        serve_cache();
    end

    function automatic logic [31:0] unmapped_inst(input logic [31:0] pc);
        return (pc & `PHYS_MASK) ^ 32'ha5a5a5a5;
    endfunction

    // waits for a delivery, checks it and lets it transfer
    task automatic expect_fetch(input logic [31:0] pc, input logic [31:0] inst,
                                input exc_pkg::fetch_exc_e exc);
        wait_fs_valid();
        check_pc("fs_pc", fs_pc, pc);
        check_inst(fs_inst, inst);
        check_exc(fs_exc, exc);
        next_cycle();
    endtask

    task automatic expect_unmapped(input logic [31:0] pc);
        expect_fetch(pc, unmapped_inst(pc), exc_pkg::EXC_NONE);
    endtask

    // redirects are one-cycle pulses
    task automatic end_pulse;
        next_cycle();
        flush        = 1'b0;
        flush_refill = 1'b0;
        refetch      = 1'b0;
        eret         = 1'b0;
        br_redirect  = 1'b0;
    endtask

    task automatic sequential_fetch;
        if (i_dut.u_ctrl.state !== fetch_pkg::ST_IDLE || fs_valid !== 1'b0) begin
            $display("fetch control is not idle after reset");
            report_failure();
        end
        expect_unmapped(`RESET_PC);
        expect_unmapped(32'hbfc00004);
        expect_unmapped(32'hbfc00008);
    endtask

    task automatic predict_and_redirect;
        bpu_valid = 1'b1;
        expect_unmapped(32'hbfc0000c);
        bpu_valid = 1'b0;
        expect_unmapped(bpu_target);
        // bfc00104 is in flight when the redirect lands
        wait_req(1'b1);
        br_redirect = 1'b1;
        end_pulse();
        expect_unmapped(br_target);
    endtask

    task automatic flush_targets;
        // refill wins over refetch
        flush        = 1'b1;
        flush_refill = 1'b1;
        refetch      = 1'b1;
        end_pulse();
        expect_unmapped(`REFILL_EX_PC);
        flush       = 1'b1;
        refetch     = 1'b1;
        br_redirect = 1'b1;
        end_pulse();
        expect_unmapped(refetch_pc);
        flush       = 1'b1;
        br_redirect = 1'b1;
        end_pulse();
        expect_unmapped(`GENERAL_EX_PC);
        // eret beats every flush
        eret         = 1'b1;
        flush        = 1'b1;
        flush_refill = 1'b1;
        end_pulse();
        expect_unmapped(epc);
    endtask

    task automatic mapped_fetch;
        logic [31:0] paddr;
        int          rises;
        // kuseg, bit 12 set so the odd page is used
        epc   = 32'h00403004;
        paddr = {tlb_pfn1, epc[11:0]};
        eret  = 1'b1;
        end_pulse();
        expect_fetch(epc, paddr ^ 32'ha5a5a5a5, exc_pkg::EXC_NONE);
        check_pc("icache_addr", req_addr, paddr);
        rises     = req_rises;
        tlb_found = 1'b0;
        expect_fetch(32'h00403008, '0, exc_pkg::EXC_TLB_REFILL);
        tlb_found = 1'b1;
        tlb_v1    = 1'b0;
        expect_fetch(32'h0040300c, '0, exc_pkg::EXC_TLB_INVALID);
        epc  = 32'hbfc00402;
        eret = 1'b1;
        end_pulse();
        expect_fetch(epc, '0, exc_pkg::EXC_ADEL);
        tlb_v1 = 1'b1;
        if (req_rises != rises) begin
            $display("a cache request was issued for a PC with a fetch exception");
            report_failure();
        end
    endtask

    task automatic back_pressure;
        int stall;
        int rises;
        fs_allowin = 1'b0;
        flush      = 1'b1;
        end_pulse();
        wait_fs_valid();
        rises = req_rises;
        stall = 1 + $urandom_range(4);
        repeat (stall) begin
            check_pc("fs_pc", fs_pc, `GENERAL_EX_PC);
            check_inst(fs_inst, unmapped_inst(`GENERAL_EX_PC));
            check_exc(fs_exc, exc_pkg::EXC_NONE);
            if (fs_valid !== 1'b1 || icache_req !== 1'b0) begin
                $display("fs_valid dropped or a cache request started while stalled");
                report_failure();
            end
            next_cycle();
        end
        if (req_rises != rises) begin
            $display("a cache request started while the fetch stage was stalled");
            report_failure();
        end
        fs_allowin = 1'b1;
        expect_unmapped(`GENERAL_EX_PC);
        expect_unmapped(32'hbfc00384);
        expect_unmapped(32'hbfc00388);
    endtask

    initial begin
        void'($urandom(32'hffee));
        repeat (2) @(posedge clk);
        #drive_delay;
        reset = 1'b0;
        sequential_fetch();
        predict_and_redirect();
        flush_targets();
        mapped_fetch();
        back_pressure();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+logic
+incdir+test
logic/fetch_pkg.sv
logic/exc_pkg.sv
logic/next_pc_sel.sv
logic/itlb_translate.sv
logic/fetch_ctrl.sv
logic/pre_fetch_top.sv
test/tb_pre_fetch.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the pre-fetch testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tb_pre_fetch -o sim_pre_fetch

sim_out=$(./obj_dir/sim_pre_fetch 2>&1) || true
echo "$sim_out"

if grep -qx "Simulation finished: PASS" <<< "$sim_out"; then
    exit 0
fi
exit 1
